// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= coreSlice_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== aluExecute.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module aluExecute (
    input  logic             clk,
    input  logic             rst,
    input  logic             regWriteE,
    input  isaPkg::aluOpT    aluOpE,
    input  logic             aluSrcE,
    input  pipePkg::wordT    rd1E,
    input  pipePkg::wordT    rd2E,
    input  pipePkg::wordT    immE,
    input  pipePkg::regAddrT rdE,
    input  pipePkg::fwdSelT  fwdA,
    input  pipePkg::fwdSelT  fwdB,
    output logic             regWriteW,
    output pipePkg::regAddrT rdW,
    output pipePkg::wordT    resultW
);

    pipePkg::wordT srcA;
    pipePkg::wordT regB;
    pipePkg::wordT srcB;
    pipePkg::wordT aluOut;

    // forwarding first, then the immediate select
    assign srcA = (fwdA == pipePkg::fwdWb) ? resultW : rd1E;
    assign regB = (fwdB == pipePkg::fwdWb) ? resultW : rd2E;
    assign srcB = aluSrcE ? immE : regB;

    always_comb begin
        case (aluOpE)
            isaPkg::aluSub:   aluOut = srcA - srcB;
            isaPkg::aluAnd:   aluOut = srcA & srcB;
            isaPkg::aluOr:    aluOut = srcA | srcB;
            isaPkg::aluXor:   aluOut = srcA ^ srcB;
            isaPkg::aluSlt:   aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            isaPkg::aluPassB: aluOut = srcB;
            default:          aluOut = srcA + srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteW <= 1'b0;
            rdW       <= '0;
            resultW   <= '0;
        end else begin
            regWriteW <= regWriteE;
            rdW       <= rdE;
            resultW   <= aluOut;
        end
    end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module controlUnit (
    input  pipePkg::wordT    instr,
    input  logic             instrValid,
    output logic             regWriteD,
    output isaPkg::aluOpT    aluOpD,
    output logic             aluSrcD,
    output pipePkg::regAddrT rs1D,
    output pipePkg::regAddrT rs2D,
    output pipePkg::regAddrT rdD,
    output pipePkg::wordT    immD
);

    isaPkg::opcodeT opcode;
    logic [2:0]     funct3;
    logic           funct7b5;
    logic           knownOp;
    isaPkg::aluOpT  f3Op;

    assign opcode   = isaPkg::opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign rs1D = instr[19:15];
    assign rs2D = instr[24:20];
    assign rdD  = instr[11:7];

    // operation from funct3, same table for R and I forms
    always_comb begin
        case (funct3)
            isaPkg::F3_SLT: f3Op = isaPkg::aluSlt;
            isaPkg::F3_XOR: f3Op = isaPkg::aluXor;
            isaPkg::F3_OR:  f3Op = isaPkg::aluOr;
            isaPkg::F3_AND: f3Op = isaPkg::aluAnd;
            default:        f3Op = isaPkg::aluAdd;
        endcase
    end

    always_comb begin
        knownOp = 1'b1;
        aluOpD  = isaPkg::aluAdd;
        aluSrcD = 1'b0;
        immD    = '0;
        case (opcode)
            isaPkg::opReg: begin
                // funct7 bit 5 turns add into sub
                if (funct3 == isaPkg::F3_ADD && funct7b5) begin
                    aluOpD = isaPkg::aluSub;
                end else begin
                    aluOpD = f3Op;
                end
            end
            isaPkg::opImm: begin
                aluOpD  = f3Op;
                aluSrcD = 1'b1;
                immD    = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            isaPkg::opLui: begin
                aluOpD  = isaPkg::aluPassB;
                aluSrcD = 1'b1;
                immD    = {instr[31:12], 12'b0};
            end
            default: knownOp = 1'b0;
        endcase
    end

    // x0 destinations never write
    assign regWriteD = instrValid && knownOp && (rdD != '0);

endmodule

// ==== coreSlice.sv ====
`timescale 1ns/1ps

module coreSlice (
    input  logic             clk,
    input  logic             rst,
    input  pipePkg::wordT    instr,
    input  logic             instrValid,
    // pc belongs to the surrounding core, nothing in this slice needs it
    input  pipePkg::wordT    pc,
    input  logic             flush,
    output logic             regWriteW,
    output pipePkg::regAddrT rdW,
    output pipePkg::wordT    resultW
);

    // decode
    logic             regWriteD;
    isaPkg::aluOpT    aluOpD;
    logic             aluSrcD;
    pipePkg::regAddrT rs1D;
    pipePkg::regAddrT rs2D;
    pipePkg::regAddrT rdD;
    pipePkg::wordT    immD;
    pipePkg::wordT    rd1D;
    pipePkg::wordT    rd2D;

    // execute
    logic             regWriteE;
    isaPkg::aluOpT    aluOpE;
    logic             aluSrcE;
    pipePkg::wordT    rd1E;
    pipePkg::wordT    rd2E;
    pipePkg::wordT    immE;
    pipePkg::regAddrT rdE;
    pipePkg::regAddrT rs1E;
    pipePkg::regAddrT rs2E;
    pipePkg::fwdSelT  fwdA;
    pipePkg::fwdSelT  fwdB;

    controlUnit ctrl (
        .instr(instr), .instrValid(instrValid),
        .regWriteD(regWriteD), .aluOpD(aluOpD), .aluSrcD(aluSrcD),
        .rs1D(rs1D), .rs2D(rs2D), .rdD(rdD), .immD(immD)
    );

    // written from writeback
    regFile regs (
        .clk(clk), .rst(rst), .rs1D(rs1D), .rs2D(rs2D),
        .we(regWriteW), .wa(rdW), .wd(resultW),
        .rd1D(rd1D), .rd2D(rd2D)
    );

    decodeExecuteReg deReg (
        .clk(clk), .rst(rst), .flush(flush),
        .regWriteD(regWriteD), .aluOpD(aluOpD), .aluSrcD(aluSrcD),
        .regWriteE(regWriteE), .aluOpE(aluOpE), .aluSrcE(aluSrcE),
        .rd1D(rd1D), .rd2D(rd2D), .immD(immD), .rdD(rdD),
        .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .rdE(rdE),
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E)
    );

    forwardUnit fwd (
        .rs1E(rs1E), .rs2E(rs2E), .rdW(rdW), .regWriteW(regWriteW),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    aluExecute exec (
        .clk(clk), .rst(rst),
        .regWriteE(regWriteE), .aluOpE(aluOpE), .aluSrcE(aluSrcE),
        .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .rdE(rdE),
        .fwdA(fwdA), .fwdB(fwdB),
        .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
    );

endmodule

// ==== coreSlice_assert.sv ====
`timescale 1ns/1ps

module coreSliceAssert (
    input logic             clk,
    input logic             rst,
    input logic             regWriteW,
    input pipePkg::regAddrT rdW
);

    // writeback idle right after reset
    noWriteAfterReset: assert property (@(posedge clk) rst |=> !regWriteW)
        else $error("writeback active in the cycle after reset");

    // x0 is never a writeback target
    writeNotX0: assert property (@(posedge clk) disable iff (rst) regWriteW |-> rdW != '0)
        else $error("writeback targets register x0");

    writeKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(regWriteW))
        else $error("regWriteW is unknown");

endmodule

bind coreSlice coreSliceAssert checks (
    .clk(clk), .rst(rst), .regWriteW(regWriteW), .rdW(rdW)
);

// ==== coreSlice_tb.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module tbClock (
    output logic clk
);

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

endmodule

module coreSlice_tb;

    // columns per vector in the data file
    localparam int FIELDS   = 6;
    localparam int MAX_VECS = 64;

    logic             clk;
    logic             rst;
    pipePkg::wordT    instr;
    logic             instrValid;
    pipePkg::wordT    pc;
    logic             flush;
    logic             regWriteW;
    pipePkg::regAddrT rdW;
    pipePkg::wordT    resultW;

    logic [31:0] vecMem [FIELDS*MAX_VECS];
    int          numVecs;
    logic        loaded;

    tbClock clkGen (.clk(clk));

    coreSlice dut (
        .clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
        .pc(pc), .flush(flush),
        .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkWrite(input int idx, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error regWriteW expected 0x%0h got 0x%0h in vector %0d",
                expected, actual, idx));
        end
    endtask

    task automatic checkRd(input int idx, input pipePkg::regAddrT expected,
                           input pipePkg::regAddrT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error rdW expected 0x%0h got 0x%0h in vector %0d",
                expected, actual, idx));
        end
    endtask

    task automatic checkResult(input int idx, input pipePkg::wordT expected,
                               input pipePkg::wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error resultW expected 0x%0h got 0x%0h in vector %0d",
                expected, actual, idx));
        end
    endtask

    task automatic checkVector(input int idx);
        logic             expWrite;
        pipePkg::regAddrT expRd;
        pipePkg::wordT    expResult;
        expWrite  = vecMem[FIELDS*idx+3][0];
        expRd     = vecMem[FIELDS*idx+4][`REG_ADDR_W-1:0];
        expResult = vecMem[FIELDS*idx+5];
        checkWrite(idx, expWrite, regWriteW);
        // rd and result only mean something when a write happens
        if (expWrite) begin
            checkRd(idx, expRd, rdW);
            checkResult(idx, expResult, resultW);
        end
    endtask

    initial begin
        int a;
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        pc         = '0;
        flush      = 1'b0;
        loaded     = 1'b0;
        numVecs    = 0;
        // valid column of an unused slot ends up far above 1
        for (a = 0; a < FIELDS*MAX_VECS; a++) begin
            vecMem[a] = 32'hFFFF0000 | a;
        end
        $readmemh("coreSlice_testdata.txt", vecMem);
        while (numVecs < MAX_VECS && vecMem[FIELDS*numVecs+1] <= 32'd1) begin
            numVecs++;
        end
        loaded = 1'b1;
        if (numVecs == 0) begin
            abortRun("no test vectors were read from the data file");
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // result of vector c shows at W two edges later
        for (int c = 0; c < numVecs + 2; c++) begin
            if (c >= 2) begin
                checkVector(c - 2);
            end
            if (c < numVecs) begin
                instr      = vecMem[FIELDS*c];
                instrValid = vecMem[FIELDS*c+1][0];
                flush      = vecMem[FIELDS*c+2][0];
                pc         = 4 * c;
            end else begin
                instr      = '0;
                instrValid = 1'b0;
                flush      = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        $display("All tests passed");
        $finish;
    end

    // watchdog, one cycle per vector plus reset and drain margin
    initial begin
        wait (loaded);
        #((numVecs + 20) * 4);
        abortRun("timeout: the run did not finish in the expected time");
    end

endmodule

// ==== coreSlice_testdata.txt ====
// instr valid flush expWrite expRd expResult, all hex
// rd and result are only checked when expWrite is 1
003100B3 1 0 1 01 00000000
00500093 1 0 1 01 00000005
00708113 1 0 1 02 0000000C
002081B3 1 0 1 03 00000011
40118233 1 0 1 04 0000000C
403082B3 1 0 1 05 FFFFFFF4
0032F333 1 0 1 06 00000010
0020E3B3 1 0 1 07 0000000D
0053C433 1 0 1 08 FFFFFFF9
0012A4B3 1 0 1 09 00000001
0050A533 1 0 1 0A 00000000
0F047593 1 0 1 0B 000000F0
F005E613 1 0 1 0C FFFFFFF0
FFF64693 1 0 1 0D 0000000F
FF52A713 1 0 1 0E 00000001
123457B7 1 0 1 0F 12345000
67878793 1 0 1 0F 12345678
00100813 1 0 1 10 00000001
10080813 1 1 0 00 00000000
00280893 1 0 1 11 00000003
00908013 1 0 0 00 00000000
05500913 0 0 0 00 00000000
0000A983 1 0 0 00 00000000
01298A33 1 0 1 14 00000000
7FF00A93 1 0 1 15 000007FF

// ==== core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path width
`define XLEN 32
`define REG_COUNT 32
// bits needed to name one register
`define REG_ADDR_W 5

`endif

// ==== decodeExecuteReg.sv ====
`timescale 1ns/1ps

module decodeExecuteReg (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,

    // control
    input  logic             regWriteD,
    input  isaPkg::aluOpT    aluOpD,
    input  logic             aluSrcD,
    output logic             regWriteE,
    output isaPkg::aluOpT    aluOpE,
    output logic             aluSrcE,

    // data
    input  pipePkg::wordT    rd1D,
    input  pipePkg::wordT    rd2D,
    input  pipePkg::wordT    immD,
    input  pipePkg::regAddrT rdD,
    output pipePkg::wordT    rd1E,
    output pipePkg::wordT    rd2E,
    output pipePkg::wordT    immE,
    output pipePkg::regAddrT rdE,

    // hazard register numbers
    input  pipePkg::regAddrT rs1D,
    input  pipePkg::regAddrT rs2D,
    output pipePkg::regAddrT rs1E,
    output pipePkg::regAddrT rs2E
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // bubble
            regWriteE <= 1'b0;
            aluOpE    <= isaPkg::aluAdd;
            aluSrcE   <= 1'b0;
            rd1E      <= '0;
            rd2E      <= '0;
            immE      <= '0;
            rdE       <= '0;
            rs1E      <= '0;
            rs2E      <= '0;
        end else begin
            regWriteE <= regWriteD;
            aluOpE    <= aluOpD;
            aluSrcE   <= aluSrcD;
            rd1E      <= rd1D;
            rd2E      <= rd2D;
            immE      <= immD;
            rdE       <= rdD;
            rs1E      <= rs1D;
            rs2E      <= rs2D;
        end
    end

endmodule

// ==== forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
    input  pipePkg::regAddrT rs1E,
    input  pipePkg::regAddrT rs2E,
    input  pipePkg::regAddrT rdW,
    input  logic             regWriteW,
    output pipePkg::fwdSelT  fwdA,
    output pipePkg::fwdSelT  fwdB
);

    // take the writeback result when it targets an execute source
    always_comb begin
        fwdA = pipePkg::fwdReg;
        fwdB = pipePkg::fwdReg;
        if (regWriteW && rdW == rs1E) begin
            fwdA = pipePkg::fwdWb;
        end
        if (regWriteW && rdW == rs2E) begin
            fwdB = pipePkg::fwdWb;
        end
    end

endmodule

// ==== isaPkg.sv ====
package isaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg = 7'b0110011,
        opImm = 7'b0010011,
        opLui = 7'b0110111
    } opcodeT;

    // aluAdd must stay zero, it is the bubble value
    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluXor   = 3'd4,
        aluSlt   = 3'd5,
        aluPassB = 3'd6
    } aluOpT;

    // funct3 codes shared by R and I forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

endpackage

// ==== pipePkg.sv ====
`include "core_cfg.svh"

package pipePkg;

    // one data word
    typedef logic [`XLEN-1:0] wordT;

    // register number
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    // operand source in execute
    typedef enum logic {
        fwdReg = 1'b0,
        fwdWb  = 1'b1
    } fwdSelT;

endpackage

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  pipePkg::regAddrT rs1D,
    input  pipePkg::regAddrT rs2D,
    input  logic             we,
    input  pipePkg::regAddrT wa,
    input  pipePkg::wordT    wd,
    output pipePkg::wordT    rd1D,
    output pipePkg::wordT    rd2D
);

    pipePkg::wordT regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-through so a same-cycle read sees the value being written
    assign rd1D = (rs1D == '0) ? '0 : (we && wa == rs1D) ? wd : regs[rs1D];
    assign rd2D = (rs2D == '0) ? '0 : (we && wa == rs2D) ? wd : regs[rs2D];

endmodule

// ==== sources.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
controlUnit.sv
regFile.sv
decodeExecuteReg.sv
forwardUnit.sv
aluExecute.sv
coreSlice.sv
coreSlice_assert.sv
coreSlice_tb.sv
